//--- common/dram_cmd_pkg.sv
// ddr4 command package: pin encodings, sequencer states and request address map
package dram_cmd_pkg;

    // command pins in order {CS_n, ACT_n, RAS_n, CAS_n, WE_n}
    // ACT only fixes the top two bits, the low three carry row[16:14]
    typedef enum logic [4:0] {
        DESEL = 5'b11111,
        MRS   = 5'b01000,
        ZQCL  = 5'b01110,
        ACT   = 5'b00000,
        RD    = 5'b01101,
        WR    = 5'b01100,
        PRE   = 5'b01010
    } cmd_t;

    // init states run top to bottom, then the access loop
    // eighteen states do not fit in four bits, so five are used
    typedef enum logic [4:0] {
        POWER_UP,
        PRE_RESET,
        RESET,
        NOP,
        // mode register loads, same order as MR_TABLE
        MR1_DLL,
        MR3,
        MR6,
        MR5,
        MR4,
        MR2,
        MR1,
        MR0,
        ZQ_CAL,
        IDLE,
        ACTIVATE,
        READ,
        WRITE,
        PRECHARGE
    } dram_state_t;

    // device address fields
    typedef logic [1:0]  bg_t;
    typedef logic [1:0]  ba_t;
    typedef logic [16:0] row_t;
    typedef logic [9:0]  col_t;

    // A13..A0 on the pins
    typedef logic [13:0] pin_addr_t;

    // flat scheduler address, {row, ba, bg, col} from top to bottom
    typedef logic [30:0] req_addr_t;

    localparam int COL_LSB = 0;
    localparam int BG_LSB  = 10;
    localparam int BA_LSB  = 12;
    localparam int ROW_LSB = 14;

    // A12 in column commands, burst length 8 on the fly
    localparam logic BL8_BIT  = 1'b1;
    // A10 in column commands, no auto precharge
    localparam logic AUTO_PRE = 1'b0;

endpackage

//--- common/dram_timing_pkg.sv
// ddr4 timing package: state intervals in clock cycles and mode register values
package dram_timing_pkg;

    // counts cycles inside one state
    typedef logic [7:0] interval_t;

    // shortened so init and access stay short in simulation
    localparam interval_t T_PWUP   = 8'd8;
    localparam interval_t T_XPR    = 8'd6;
    localparam interval_t T_DLLK   = 8'd8;
    localparam interval_t T_MOD    = 8'd4;
    localparam interval_t T_ZQINIT = 8'd8;
    localparam interval_t T_RCD    = 8'd4;
    // cas latency plus burst
    localparam interval_t T_READ   = 8'd6;
    // write latency plus write recovery plus burst
    localparam interval_t T_WRITE  = 8'd10;
    localparam interval_t T_RP     = 8'd4;
    // idle is re-evaluated every cycle
    localparam interval_t T_IDLE   = 8'd1;

    // one mode register load on the pins
    typedef struct packed {
        dram_cmd_pkg::bg_t       bg;
        dram_cmd_pkg::ba_t       ba;
        dram_cmd_pkg::pin_addr_t addr;
    } mr_load_t;

    // indexed by load order, MR1_DLL first and MR0 last
    localparam mr_load_t MR_TABLE [8] = '{
        '{bg: 2'd0, ba: 2'd1, addr: 14'h0001},
        '{bg: 2'd0, ba: 2'd3, addr: 14'h0000},
        '{bg: 2'd1, ba: 2'd2, addr: 14'h080F},
        '{bg: 2'd1, ba: 2'd1, addr: 14'h0000},
        '{bg: 2'd1, ba: 2'd0, addr: 14'h1000},
        '{bg: 2'd0, ba: 2'd2, addr: 14'h0088},
        '{bg: 2'd0, ba: 2'd1, addr: 14'h0001},
        '{bg: 2'd0, ba: 2'd0, addr: 14'h041D}
    };

    // long zq calibration, A10 high
    localparam dram_cmd_pkg::pin_addr_t ZQ_ADDR = 14'h0400;

endpackage

//--- hdl/dram_request_decode.sv
// request decoder: splits the scheduler address and holds the accepted access
module dram_request_decode (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    req_read,
    input  logic                    req_write,
    input  dram_cmd_pkg::req_addr_t req_addr,
    input  logic                    accept,
    output logic                    req_pending,
    output logic                    req_is_write,
    output dram_cmd_pkg::bg_t       acc_bg,
    output dram_cmd_pkg::ba_t       acc_ba,
    output dram_cmd_pkg::row_t      acc_row,
    output dram_cmd_pkg::col_t      acc_col
);

    // fields of the live request
    dram_cmd_pkg::bg_t  req_bg;
    dram_cmd_pkg::ba_t  req_ba;
    dram_cmd_pkg::row_t req_row;
    dram_cmd_pkg::col_t req_col;

    // kind of the live request, write wins when both are up
    logic req_kind_write;

    // address split by the package map
    assign req_col = req_addr[dram_cmd_pkg::COL_LSB +: $bits(dram_cmd_pkg::col_t)];
    assign req_bg  = req_addr[dram_cmd_pkg::BG_LSB +: $bits(dram_cmd_pkg::bg_t)];
    assign req_ba  = req_addr[dram_cmd_pkg::BA_LSB +: $bits(dram_cmd_pkg::ba_t)];
    assign req_row = req_addr[dram_cmd_pkg::ROW_LSB +: $bits(dram_cmd_pkg::row_t)];

    assign req_pending    = req_read | req_write;
    assign req_kind_write = req_write;

    // kind of the access in flight, steers ACTIVATE to READ or WRITE
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            req_is_write <= 1'b0;
        end else if (accept) begin
            req_is_write <= req_kind_write;
        end
    end

    // address fields held from accept until the next accept
    always_ff @(posedge CLK) begin
        if (accept) begin
            acc_bg  <= req_bg;
            acc_ba  <= req_ba;
            acc_row <= req_row;
            acc_col <= req_col;
        end
    end

endmodule

//--- sequencer/dram_interval_timer.sv
// interval timer: counts cycles in the current state and flags its first and last
module dram_interval_timer (
    input  logic                      CLK,
    input  logic                      nRST,
    input  dram_cmd_pkg::dram_state_t state,
    output logic                      first_cycle,
    output logic                      last_cycle
);

    dram_timing_pkg::interval_t count;
    dram_timing_pkg::interval_t len;
    dram_timing_pkg::interval_t last_count;

    // interval of the current state
    always_comb begin
        case (state)
            dram_cmd_pkg::POWER_UP,
            dram_cmd_pkg::PRE_RESET,
            dram_cmd_pkg::RESET:     len = dram_timing_pkg::T_PWUP;
            dram_cmd_pkg::NOP:       len = dram_timing_pkg::T_XPR;
            dram_cmd_pkg::MR1_DLL:   len = dram_timing_pkg::T_DLLK;
            dram_cmd_pkg::MR3,
            dram_cmd_pkg::MR6,
            dram_cmd_pkg::MR5,
            dram_cmd_pkg::MR4,
            dram_cmd_pkg::MR2,
            dram_cmd_pkg::MR1,
            dram_cmd_pkg::MR0:       len = dram_timing_pkg::T_MOD;
            dram_cmd_pkg::ZQ_CAL:    len = dram_timing_pkg::T_ZQINIT;
            dram_cmd_pkg::ACTIVATE:  len = dram_timing_pkg::T_RCD;
            dram_cmd_pkg::READ:      len = dram_timing_pkg::T_READ;
            dram_cmd_pkg::WRITE:     len = dram_timing_pkg::T_WRITE;
            dram_cmd_pkg::PRECHARGE: len = dram_timing_pkg::T_RP;
            // idle and unused codes
            default:                 len = dram_timing_pkg::T_IDLE;
        endcase
    end

    assign last_count = len - 8'd1;

    assign first_cycle = (count == '0);
    assign last_cycle  = (count == last_count);

    // wraps at the last count, the sequencer moves on at the same edge
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count <= '0;
        end else if (last_cycle) begin
            count <= '0;
        end else begin
            count <= count + 8'd1;
        end
    end

endmodule

//--- sequencer/dram_sequencer.sv
// command sequencer FSM: device init, then closed-page read and write accesses
module dram_sequencer (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic                      req_pending,
    input  logic                      req_is_write,
    input  logic                      last_cycle,
    output dram_cmd_pkg::dram_state_t state,
    output logic                      accept,
    output logic                      request_done
);

    dram_cmd_pkg::dram_state_t next_state;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= dram_cmd_pkg::POWER_UP;
        end else begin
            state <= next_state;
        end
    end

    // a state is left only in its last cycle
    always_comb begin
        next_state = state;
        if (last_cycle) begin
            case (state)
                // power up and reset of the device
                dram_cmd_pkg::POWER_UP: begin
                    next_state = dram_cmd_pkg::PRE_RESET;
                end
                dram_cmd_pkg::PRE_RESET: begin
                    next_state = dram_cmd_pkg::RESET;
                end
                dram_cmd_pkg::RESET: begin
                    next_state = dram_cmd_pkg::NOP;
                end
                dram_cmd_pkg::NOP: begin
                    next_state = dram_cmd_pkg::MR1_DLL;
                end
                // mode register loads
                dram_cmd_pkg::MR1_DLL: begin
                    next_state = dram_cmd_pkg::MR3;
                end
                dram_cmd_pkg::MR3: begin
                    next_state = dram_cmd_pkg::MR6;
                end
                dram_cmd_pkg::MR6: begin
                    next_state = dram_cmd_pkg::MR5;
                end
                dram_cmd_pkg::MR5: begin
                    next_state = dram_cmd_pkg::MR4;
                end
                dram_cmd_pkg::MR4: begin
                    next_state = dram_cmd_pkg::MR2;
                end
                dram_cmd_pkg::MR2: begin
                    next_state = dram_cmd_pkg::MR1;
                end
                dram_cmd_pkg::MR1: begin
                    next_state = dram_cmd_pkg::MR0;
                end
                dram_cmd_pkg::MR0: begin
                    next_state = dram_cmd_pkg::ZQ_CAL;
                end
                dram_cmd_pkg::ZQ_CAL: begin
                    next_state = dram_cmd_pkg::IDLE;
                end
                // idle repeats until a request shows up
                dram_cmd_pkg::IDLE: begin
                    if (req_pending) begin
                        next_state = dram_cmd_pkg::ACTIVATE;
                    end
                end
                // column command by the captured kind
                dram_cmd_pkg::ACTIVATE: begin
                    next_state = req_is_write ? dram_cmd_pkg::WRITE : dram_cmd_pkg::READ;
                end
                dram_cmd_pkg::READ, dram_cmd_pkg::WRITE: begin
                    next_state = dram_cmd_pkg::PRECHARGE;
                end
                // closed page, always back to idle
                dram_cmd_pkg::PRECHARGE: begin
                    next_state = dram_cmd_pkg::IDLE;
                end
                // unused codes restart the init
                default: begin
                    next_state = dram_cmd_pkg::POWER_UP;
                end
            endcase
        end
    end

    // idle lasts one cycle, so a pending request is taken at once
    assign accept = (state == dram_cmd_pkg::IDLE) && req_pending;

    // end of the data phase
    assign request_done = ((state == dram_cmd_pkg::READ) ||
                           (state == dram_cmd_pkg::WRITE)) && last_cycle;

endmodule

//--- hdl/dram_command_encoder.sv
// command encoder: drives ddr4 command, bank and address pins from the FSM state
module dram_command_encoder (
    input  dram_cmd_pkg::dram_state_t state,
    input  logic                      first_cycle,
    input  dram_cmd_pkg::bg_t         acc_bg,
    input  dram_cmd_pkg::ba_t         acc_ba,
    input  dram_cmd_pkg::row_t        acc_row,
    input  dram_cmd_pkg::col_t        acc_col,
    output logic                      cs_n,
    output logic                      act_n,
    output logic                      ras_n_a16,
    output logic                      cas_n_a15,
    output logic                      we_n_a14,
    output logic                      reset_n,
    output logic                      cke,
    output dram_cmd_pkg::bg_t         bg,
    output dram_cmd_pkg::ba_t         ba,
    output dram_cmd_pkg::pin_addr_t   addr
);

    dram_cmd_pkg::cmd_t cmd;
    dram_timing_pkg::mr_load_t mr_load;

    // position of the load in MR_TABLE
    logic [2:0] mr_idx;

    assign mr_idx  = 3'(state - dram_cmd_pkg::MR1_DLL);
    assign mr_load = dram_timing_pkg::MR_TABLE[mr_idx];

    always_comb begin
        // deselect with quiet bank and address pins
        cmd  = dram_cmd_pkg::DESEL;
        bg   = '0;
        ba   = '0;
        addr = '0;
        // a command goes out only in the first cycle of its state
        if (first_cycle) begin
            case (state)
                dram_cmd_pkg::MR1_DLL,
                dram_cmd_pkg::MR3,
                dram_cmd_pkg::MR6,
                dram_cmd_pkg::MR5,
                dram_cmd_pkg::MR4,
                dram_cmd_pkg::MR2,
                dram_cmd_pkg::MR1,
                dram_cmd_pkg::MR0: begin
                    cmd  = dram_cmd_pkg::MRS;
                    bg   = mr_load.bg;
                    ba   = mr_load.ba;
                    addr = mr_load.addr;
                end
                dram_cmd_pkg::ZQ_CAL: begin
                    cmd  = dram_cmd_pkg::ZQCL;
                    addr = dram_timing_pkg::ZQ_ADDR;
                end
                // row[16:14] go out on ras/cas/we below
                dram_cmd_pkg::ACTIVATE: begin
                    cmd  = dram_cmd_pkg::ACT;
                    bg   = acc_bg;
                    ba   = acc_ba;
                    addr = acc_row[13:0];
                end
                dram_cmd_pkg::READ, dram_cmd_pkg::WRITE: begin
                    cmd  = (state == dram_cmd_pkg::WRITE) ? dram_cmd_pkg::WR : dram_cmd_pkg::RD;
                    bg   = acc_bg;
                    ba   = acc_ba;
                    // A12 burst chop bit, A10 auto precharge
                    addr = {1'b0, dram_cmd_pkg::BL8_BIT, 1'b0, dram_cmd_pkg::AUTO_PRE, acc_col};
                end
                // single bank, A10 stays low
                dram_cmd_pkg::PRECHARGE: begin
                    cmd = dram_cmd_pkg::PRE;
                    bg  = acc_bg;
                    ba  = acc_ba;
                end
                default: begin
                    cmd = dram_cmd_pkg::DESEL;
                end
            endcase
        end
    end

    // activate shares ras/cas/we with the top row bits
    assign {cs_n, act_n, ras_n_a16, cas_n_a15, we_n_a14} =
        (cmd == dram_cmd_pkg::ACT) ? {cmd[4:3], acc_row[16:14]} : cmd;

    // device reset held through power up
    assign reset_n = !((state == dram_cmd_pkg::POWER_UP) ||
                       (state == dram_cmd_pkg::PRE_RESET));

    // cke rises one state after reset_n
    assign cke = !((state == dram_cmd_pkg::POWER_UP) ||
                   (state == dram_cmd_pkg::PRE_RESET) ||
                   (state == dram_cmd_pkg::RESET));

endmodule

//--- hdl/dram_command.sv
// ddr4 command sequencer top: decoder, FSM, interval timer and pin encoder
module dram_command (
    input  logic                    CLK,
    input  logic                    nRST,
    // scheduler side
    input  logic                    req_read,
    input  logic                    req_write,
    input  dram_cmd_pkg::req_addr_t req_addr,
    output logic                    request_done,
    // device side
    output logic                    cs_n,
    output logic                    act_n,
    output logic                    ras_n_a16,
    output logic                    cas_n_a15,
    output logic                    we_n_a14,
    output dram_cmd_pkg::bg_t       bg,
    output dram_cmd_pkg::ba_t       ba,
    output dram_cmd_pkg::pin_addr_t addr,
    output logic                    reset_n,
    output logic                    cke
);

    // decoder to sequencer
    logic req_pending;
    logic req_is_write;
    logic accept;

    // held access fields
    dram_cmd_pkg::bg_t  acc_bg;
    dram_cmd_pkg::ba_t  acc_ba;
    dram_cmd_pkg::row_t acc_row;
    dram_cmd_pkg::col_t acc_col;

    // state and its cycle markers
    dram_cmd_pkg::dram_state_t state;
    logic first_cycle;
    logic last_cycle;

    dram_request_decode u_decode (
        .CLK          (CLK),
        .nRST         (nRST),
        .req_read     (req_read),
        .req_write    (req_write),
        .req_addr     (req_addr),
        .accept       (accept),
        .req_pending  (req_pending),
        .req_is_write (req_is_write),
        .acc_bg       (acc_bg),
        .acc_ba       (acc_ba),
        .acc_row      (acc_row),
        .acc_col      (acc_col)
    );

    dram_sequencer u_sequencer (
        .CLK          (CLK),
        .nRST         (nRST),
        .req_pending  (req_pending),
        .req_is_write (req_is_write),
        .last_cycle   (last_cycle),
        .state        (state),
        .accept       (accept),
        .request_done (request_done)
    );

    dram_interval_timer u_timer (
        .CLK         (CLK),
        .nRST        (nRST),
        .state       (state),
        .first_cycle (first_cycle),
        .last_cycle  (last_cycle)
    );

    dram_command_encoder u_encoder (
        .state       (state),
        .first_cycle (first_cycle),
        .acc_bg      (acc_bg),
        .acc_ba      (acc_ba),
        .acc_row     (acc_row),
        .acc_col     (acc_col),
        .cs_n        (cs_n),
        .act_n       (act_n),
        .ras_n_a16   (ras_n_a16),
        .cas_n_a15   (cas_n_a15),
        .we_n_a14    (we_n_a14),
        .reset_n     (reset_n),
        .cke         (cke),
        .bg          (bg),
        .ba          (ba),
        .addr        (addr)
    );

endmodule

//--- test/dram_command_assert.sv
// pin protocol assertions for the ddr4 command sequencer, bound to its top level
module dram_command_assert (
    input logic CLK,
    input logic nRST,
    input logic cs_n,
    input logic act_n,
    input logic reset_n,
    input logic cke,
    input logic request_done
);

    // raised by any failing assertion, polled by the testbench
    logic fired = 1'b0;

    // activate is always a selected command
    act_selects: assert property (@(posedge CLK) disable iff (!nRST) !act_n |-> !cs_n)
        else begin
            fired = 1'b1;
            $error("act_n low while cs_n is high");
        end

    // cke stays low while the device is in reset
    reset_holds_cke: assert property (@(posedge CLK) disable iff (!nRST) !reset_n |-> !cke)
        else begin
            fired = 1'b1;
            $error("cke high while reset_n is low");
        end

    // done is a single cycle pulse
    done_single: assert property (@(posedge CLK) disable iff (!nRST)
        request_done |=> !request_done)
        else begin
            fired = 1'b1;
            $error("request_done high for two cycles");
        end

endmodule

bind dram_command dram_command_assert u_assert (
    .CLK          (CLK),
    .nRST         (nRST),
    .cs_n         (cs_n),
    .act_n        (act_n),
    .reset_n      (reset_n),
    .cke          (cke),
    .request_done (request_done)
);

//--- test/dram_command_tb.sv
// testbench for the ddr4 command sequencer: init sequence and closed-page accesses
module dram_command_tb;

    localparam int NUM_ENTRIES = 10;
    // reset, power up, nop, mode loads, zq and the first idle cycle
    localparam int INIT_CYCLES = 3 + 3 * dram_timing_pkg::T_PWUP + dram_timing_pkg::T_XPR
        + dram_timing_pkg::T_DLLK + 7 * dram_timing_pkg::T_MOD + dram_timing_pkg::T_ZQINIT + 1;
    localparam int MARGIN = 50;

    // {bg, ba, addr} of each mode register load, MR1 with dll first and MR0 last
    localparam logic [17:0] MR_EXPECT [8] = '{
        {2'd0, 2'd1, 14'h0001},
        {2'd0, 2'd3, 14'h0000},
        {2'd1, 2'd2, 14'h080F},
        {2'd1, 2'd1, 14'h0000},
        {2'd1, 2'd0, 14'h1000},
        {2'd0, 2'd2, 14'h0088},
        {2'd0, 2'd1, 14'h0001},
        {2'd0, 2'd0, 14'h041D}
    };

    // one scheduler request, repeats above 1 keep it held past request_done
    typedef struct {
        logic                    rd;
        logic                    wr;
        logic                    fixed;
        dram_cmd_pkg::req_addr_t addr;
        int                      gap;
        int                      repeats;
    } entry_t;

    logic                    CLK;
    logic                    nRST;
    logic                    req_read;
    logic                    req_write;
    dram_cmd_pkg::req_addr_t req_addr;
    logic                    request_done;
    logic                    cs_n;
    logic                    act_n;
    logic                    ras_n_a16;
    logic                    cas_n_a15;
    logic                    we_n_a14;
    dram_cmd_pkg::bg_t       bg;
    dram_cmd_pkg::ba_t       ba;
    dram_cmd_pkg::pin_addr_t addr;
    logic                    reset_n;
    logic                    cke;

    entry_t stim [NUM_ENTRIES];
    int     cyc;
    int     cycle_count;
    int     cycle_limit;

    dram_command UUT (
        .CLK          (CLK),
        .nRST         (nRST),
        .req_read     (req_read),
        .req_write    (req_write),
        .req_addr     (req_addr),
        .request_done (request_done),
        .cs_n         (cs_n),
        .act_n        (act_n),
        .ras_n_a16    (ras_n_a16),
        .cas_n_a15    (cas_n_a15),
        .we_n_a14     (we_n_a14),
        .bg           (bg),
        .ba           (ba),
        .addr         (addr),
        .reset_n      (reset_n),
        .cke          (cke)
    );

    initial begin
        CLK = 1'b0;
        forever begin
            #4 CLK = ~CLK;
        end
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    // command pins as one word
    function automatic dram_cmd_pkg::cmd_t pins();
        return dram_cmd_pkg::cmd_t'({cs_n, act_n, ras_n_a16, cas_n_a15, we_n_a14});
    endfunction

    task automatic check_cmd(input dram_cmd_pkg::cmd_t got, input dram_cmd_pkg::cmd_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("** Error @ %0t: cycle %0d command pins %b, expected %b",
                $time, cyc, got, exp));
        end
    endtask

    task automatic check_bank(input dram_cmd_pkg::bg_t got_bg, input dram_cmd_pkg::ba_t got_ba,
                              input dram_cmd_pkg::bg_t exp_bg, input dram_cmd_pkg::ba_t exp_ba);
        if ((got_bg !== exp_bg) || (got_ba !== exp_ba)) begin
            stop_with_failure($sformatf("** Error @ %0t: cycle %0d bg/ba %0d/%0d, expected %0d/%0d",
                $time, cyc, got_bg, got_ba, exp_bg, exp_ba));
        end
    endtask

    task automatic check_addr(input dram_cmd_pkg::pin_addr_t got,
                              input dram_cmd_pkg::pin_addr_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("** Error @ %0t: cycle %0d addr %h, expected %h",
                $time, cyc, got, exp));
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            stop_with_failure($sformatf("** Error @ %0t: cycle %0d %s is %b, expected %b",
                $time, cyc, name, got, exp));
        end
    endtask

    // outputs settle after the rising edge, so look at them on the falling one
    task automatic next_cycle();
        @(negedge CLK);
        cyc++;
        if (UUT.u_assert.fired) begin
            stop_with_failure("a pin protocol assertion failed, see the message above");
        end
    endtask

    // deselect cycles with given reset_n and cke levels
    task automatic quiet_cycles(input int n, input logic exp_rst, input logic exp_cke);
        for (int i = 0; i < n; i++) begin
            next_cycle();
            check_cmd(pins(), dram_cmd_pkg::DESEL);
            check_level(reset_n, exp_rst, "reset_n");
            check_level(cke, exp_cke, "cke");
            check_level(request_done, 1'b0, "request_done");
        end
    endtask

    // one state: command in the first cycle, deselect after, done in the last if asked
    task automatic play_state(input int len, input dram_cmd_pkg::cmd_t cmd,
                              input dram_cmd_pkg::bg_t e_bg, input dram_cmd_pkg::ba_t e_ba,
                              input dram_cmd_pkg::pin_addr_t e_addr, input logic done_last);
        for (int i = 0; i < len; i++) begin
            next_cycle();
            if (i == 0) begin
                check_cmd(pins(), cmd);
                check_bank(bg, ba, e_bg, e_ba);
                check_addr(addr, e_addr);
            end else begin
                check_cmd(pins(), dram_cmd_pkg::DESEL);
            end
            check_level(reset_n, 1'b1, "reset_n");
            check_level(cke, 1'b1, "cke");
            check_level(request_done, done_last && (i == len - 1), "request_done");
        end
    endtask

    task automatic run_init();
        // cycle 0 of power up was already seen with nRST low
        quiet_cycles(2 * dram_timing_pkg::T_PWUP - 1, 1'b0, 1'b0);
        quiet_cycles(dram_timing_pkg::T_PWUP, 1'b1, 1'b0);
        quiet_cycles(dram_timing_pkg::T_XPR, 1'b1, 1'b1);
        for (int i = 0; i < 8; i++) begin
            play_state((i == 0) ? dram_timing_pkg::T_DLLK : dram_timing_pkg::T_MOD,
                       dram_cmd_pkg::MRS, MR_EXPECT[i][17:16], MR_EXPECT[i][15:14],
                       MR_EXPECT[i][13:0], 1'b0);
        end
        play_state(dram_timing_pkg::T_ZQINIT, dram_cmd_pkg::ZQCL, '0, '0, 14'h0400, 1'b0);
        // first idle cycle
        quiet_cycles(1, 1'b1, 1'b1);
    endtask

    task automatic run_entry(input int k);
        dram_cmd_pkg::row_t row;
        dram_cmd_pkg::ba_t  e_ba;
        dram_cmd_pkg::bg_t  e_bg;
        dram_cmd_pkg::col_t col;
        logic               is_wr;
        // row on top, then bank, bank group and column at the bottom
        row   = stim[k].addr[30:14];
        e_ba  = stim[k].addr[13:12];
        e_bg  = stim[k].addr[11:10];
        col   = stim[k].addr[9:0];
        is_wr = stim[k].wr;
        quiet_cycles(stim[k].gap, 1'b1, 1'b1);
        req_read  = stim[k].rd;
        req_write = stim[k].wr;
        req_addr  = stim[k].addr;
        for (int r = 0; r < stim[k].repeats; r++) begin
            // top row bits ride on ras/cas/we
            play_state(dram_timing_pkg::T_RCD, dram_cmd_pkg::cmd_t'({2'b00, row[16:14]}),
                       e_bg, e_ba, row[13:0], 1'b0);
            play_state(is_wr ? dram_timing_pkg::T_WRITE : dram_timing_pkg::T_READ,
                       is_wr ? dram_cmd_pkg::WR : dram_cmd_pkg::RD,
                       e_bg, e_ba, {1'b0, 1'b1, 1'b0, 1'b0, col}, 1'b1);
            // scheduler lets go after the last done pulse
            if (r == stim[k].repeats - 1) begin
                req_read  = 1'b0;
                req_write = 1'b0;
            end
            play_state(dram_timing_pkg::T_RP, dram_cmd_pkg::PRE, e_bg, e_ba, '0, 1'b0);
            quiet_cycles(1, 1'b1, 1'b1);
        end
    endtask

    task automatic fill_table();
        // read, write, both at once, then held read and write served twice
        stim[0] = '{1'b1, 1'b0, 1'b1, {17'h1_2345, 2'd2, 2'd1, 10'h155}, 0, 1};
        stim[1] = '{1'b0, 1'b1, 1'b1, {17'h0_0F0F, 2'd1, 2'd3, 10'h2AA}, 3, 1};
        stim[2] = '{1'b1, 1'b1, 1'b1, {17'h1_FFFF, 2'd3, 2'd0, 10'h3FF}, 2, 1};
        stim[3] = '{1'b1, 1'b0, 1'b1, {17'h0_8001, 2'd0, 2'd2, 10'h001}, 0, 2};
        stim[4] = '{1'b0, 1'b1, 1'b1, {17'h1_0000, 2'd1, 2'd1, 10'h200}, 1, 2};
        // random addresses
        stim[5] = '{1'b1, 1'b0, 1'b0, '0, 0, 1};
        stim[6] = '{1'b0, 1'b1, 1'b0, '0, 4, 1};
        stim[7] = '{1'b1, 1'b0, 1'b0, '0, 1, 1};
        stim[8] = '{1'b1, 1'b1, 1'b0, '0, 0, 1};
        stim[9] = '{1'b0, 1'b1, 1'b0, '0, 2, 1};
        for (int k = 0; k < NUM_ENTRIES; k++) begin
            if (!stim[k].fixed) begin
                stim[k].addr = 31'($urandom());
            end
        end
    endtask

    // init plus every access with its gap and idle cycle
    function automatic int run_length();
        int total;
        total = INIT_CYCLES + MARGIN;
        for (int k = 0; k < NUM_ENTRIES; k++) begin
            total += stim[k].gap + stim[k].repeats * (dram_timing_pkg::T_RCD
                + (stim[k].wr ? dram_timing_pkg::T_WRITE : dram_timing_pkg::T_READ)
                + dram_timing_pkg::T_RP + 1);
        end
        return total;
    endfunction

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge CLK);
            cycle_count++;
            if (cycle_count > cycle_limit) begin
                stop_with_failure($sformatf("timeout: test did not finish within %0d cycles",
                    cycle_limit));
            end
        end
    end

    initial begin
        void'($urandom(32'habce_4af4));
        cyc       = 0;
        nRST      = 1'b0;
        req_read  = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        fill_table();
        cycle_limit = run_length();
        // device held in reset, pins quiet
        quiet_cycles(3, 1'b0, 1'b0);
        nRST = 1'b1;
        run_init();
        for (int k = 0; k < NUM_ENTRIES; k++) begin
            run_entry(k);
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

//--- dram_command.f
common/dram_cmd_pkg.sv
common/dram_timing_pkg.sv
hdl/dram_request_decode.sv
sequencer/dram_interval_timer.sv
sequencer/dram_sequencer.sv
hdl/dram_command_encoder.sv
hdl/dram_command.sv
test/dram_command_assert.sv
test/dram_command_tb.sv

//--- Bender.yml
package:
  name: dram_command

sources:
  # packages first, the address and timing types are used everywhere
  - common/dram_cmd_pkg.sv
  - common/dram_timing_pkg.sv
  # design
  - hdl/dram_request_decode.sv
  - sequencer/dram_interval_timer.sv
  - sequencer/dram_sequencer.sv
  - hdl/dram_command_encoder.sv
  - hdl/dram_command.sv
  # testbench
  - target: test
    files:
      - test/dram_command_assert.sv
      - test/dram_command_tb.sv
